// File: sources.f
verilog/uart_cmd_pkg.sv
verilog/byte_fifo_if.sv
verilog/uart_cmd_sequencer.sv
verilog/byte_fifo.sv
verilog/uart_tx_serializer.sv
verilog/uart_rx_deserializer.sv
verilog/uart_cmd_bridge.sv
sim/uart_cmd_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f sources.f --top-module uart_cmd_bridge_tb -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sim/uart_cmd_bridge_tb.sv
module uart_cmd_bridge_tb;

  typedef enum int {RESP_GOOD, RESP_BAD_PAR, RESP_BAD_STOP, RESP_NONE} resp_mode_e;

  typedef struct {
    logic                is_read;
    uart_cmd_pkg::cmd_t  cmd;
    uart_cmd_pkg::byte_t resp;
    resp_mode_e          mode;
    uart_cmd_pkg::byte_t exp_data;
    logic                exp_err;
  } row_t;

  logic                clk;
  logic                rst_n;
  uart_cmd_pkg::cmd_t  cmd_in;
  logic                cmd_vld;
  logic                cmd_rdy;
  logic                rx;
  logic                tx;
  uart_cmd_pkg::byte_t read_data;
  logic                read_rdy;
  logic                read_err;

  row_t                rows [12];
  uart_cmd_pkg::byte_t exp_bytes [$];
  uart_cmd_pkg::byte_t dev_bytes [$];  // decoded off tx.
  logic [31:0]         rng_state = 32'd66969;
  int                  err_count = 0;
  int                  cycle = 0;
  int                  last_frame_end = -1000;
  logic                resp_armed = 1'b0;
  uart_cmd_pkg::byte_t resp_byte;
  resp_mode_e          resp_mode;
  event                frame_seen;

  uart_cmd_bridge uart_cmd_bridge_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit from the row count.
  initial
  begin
    int run_limit;
    run_limit = $size(rows) * (2 * (uart_cmd_pkg::FRAME_BITS + uart_cmd_pkg::GAP_BITS)
                + uart_cmd_pkg::RESP_TIMEOUT_BITS + 16) * uart_cmd_pkg::CLKS_PER_BIT;
    while (cycle < run_limit)
    begin
      @(posedge clk);
      cycle = cycle + 1;
    end
    $display("test did not finish within %0d cycles", run_limit);
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %0h got %0h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic send_command(input uart_cmd_pkg::cmd_t cmd);
    @(negedge clk);
    while (cmd_rdy !== 1'b1)
      @(negedge clk);
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);  // accepted here.
    cmd_vld <= 1'b0;
  endtask

  task automatic run_read(input row_t r);
    int accept_cycle;
    while (dev_bytes.size() < exp_bytes.size())
      @(posedge clk);
    exp_bytes.push_back(r.cmd[15:8]);
    resp_byte  = r.resp;
    resp_mode  = r.mode;
    resp_armed = 1'b1;
    send_command(r.cmd);
    @(negedge clk);
    accept_cycle = cycle;
    while (read_rdy !== 1'b1)
    begin
      check_value("cmd_rdy", 32'(0), 32'(cmd_rdy));
      @(negedge clk);
    end
    check_value("cmd_rdy", 32'(0), 32'(cmd_rdy));
    check_value("read_err", 32'(r.exp_err), 32'(read_err));
    if (r.mode == RESP_GOOD || r.mode == RESP_NONE)
      check_value("read_data", 32'(r.exp_data), 32'(read_data));
    if (r.mode == RESP_NONE &&
        cycle - accept_cycle < uart_cmd_pkg::RESP_TIMEOUT_BITS * uart_cmd_pkg::CLKS_PER_BIT)
    begin
      $display("read without response ended before the timeout");
      err_count++;
    end
    @(negedge clk);
    check_value("read_rdy", 32'(0), 32'(read_rdy));  // single pulse.
  endtask

  // device model, samples every cycle of a frame.
  initial
  begin
    logic [uart_cmd_pkg::FRAME_BITS*uart_cmd_pkg::CLKS_PER_BIT-1:0] smp;
    logic [uart_cmd_pkg::FRAME_BITS-1:0]                            bits;
    logic                                                           tx_prev;
    logic                                                           steady;
    int                                                             frame_start;
    int                                                             j;
    int                                                             k;
    tx_prev = 1'b1;
    forever
    begin
      @(negedge clk);
      if (tx_prev === 1'b1 && tx === 1'b0)
      begin
        frame_start = cycle;
        steady      = 1'b1;
        smp[0]      = tx;
        for (j = 1; j < uart_cmd_pkg::FRAME_BITS * uart_cmd_pkg::CLKS_PER_BIT; j++)
        begin
          @(negedge clk);
          smp[j] = tx;
        end
        for (k = 0; k < uart_cmd_pkg::FRAME_BITS; k++)
        begin
          bits[k] = smp[k*uart_cmd_pkg::CLKS_PER_BIT + uart_cmd_pkg::CLKS_PER_BIT/2];
          for (j = 0; j < uart_cmd_pkg::CLKS_PER_BIT; j++)
          begin
            if (smp[k*uart_cmd_pkg::CLKS_PER_BIT + j] !== bits[k])
              steady = 1'b0;
          end
        end
        if (!steady)
        begin
          $display("tx changed inside a bit period of a frame");
          err_count++;
        end
        check_value("tx_start", 32'(0), 32'(bits[0]));
        check_value("tx_parity", 32'(1), 32'(^bits[9:1]));  // odd over data and parity.
        check_value("tx_stop", 32'(1), 32'(bits[10]));
        if (frame_start - last_frame_end < uart_cmd_pkg::GAP_BITS * uart_cmd_pkg::CLKS_PER_BIT)
        begin
          $display("idle gap before a frame was only %0d cycles", frame_start - last_frame_end);
          err_count++;
        end
        last_frame_end = frame_start + uart_cmd_pkg::FRAME_BITS * uart_cmd_pkg::CLKS_PER_BIT;
        dev_bytes.push_back(bits[8:1]);
        -> frame_seen;
      end
      tx_prev = tx;
    end
  end

  // response side of the device.
  initial
  begin
    logic [uart_cmd_pkg::FRAME_BITS-1:0] bits;
    logic                                par;
    int                                  k;
    forever
    begin
      @(frame_seen);
      if (resp_armed)
      begin
        resp_armed = 1'b0;
        par  = ~^resp_byte ^ (resp_mode == RESP_BAD_PAR);
        bits = {resp_mode != RESP_BAD_STOP, par, resp_byte, 1'b0};
        repeat (2 * uart_cmd_pkg::CLKS_PER_BIT) @(posedge clk);
        if (resp_mode != RESP_NONE)
        begin
          for (k = 0; k < uart_cmd_pkg::FRAME_BITS; k++)
          begin
            rx <= bits[k];
            repeat (uart_cmd_pkg::CLKS_PER_BIT) @(posedge clk);
          end
          rx <= 1'b1;
        end
      end
    end
  end

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    // read, cmd, response, mode, read_data, read_err.
    rows = '{
      '{1'b0, 16'hA55A, 8'h00, RESP_NONE,     8'h00, 1'b0},
      '{1'b0, 16'h8000, 8'h00, RESP_NONE,     8'h00, 1'b0},
      '{1'b1, 16'h3C00, 8'h5A, RESP_GOOD,     8'h5A, 1'b0},
      '{1'b1, 16'h0000, 8'h00, RESP_GOOD,     8'h00, 1'b0},
      '{1'b1, 16'h1200, 8'h77, RESP_BAD_PAR,  8'h77, 1'b1},
      '{1'b1, 16'h1300, 8'h80, RESP_BAD_STOP, 8'h80, 1'b1},
      '{1'b1, 16'h1400, 8'h00, RESP_NONE,     8'h00, 1'b1},
      '{1'b0, 16'h8000, 8'h00, RESP_NONE,     8'h00, 1'b0},
      '{1'b0, 16'h8000, 8'h00, RESP_NONE,     8'h00, 1'b0},
      '{1'b0, 16'h8000, 8'h00, RESP_NONE,     8'h00, 1'b0},
      '{1'b0, 16'h8000, 8'h00, RESP_NONE,     8'h00, 1'b0},
      '{1'b1, 16'h0F00, 8'h00, RESP_GOOD,     8'h00, 1'b0}
    };
    foreach (rows[i])
    begin
      if (!rows[i].is_read && i != 0)
        rows[i].cmd[14:0] = 15'(next_random());  // random low bits for writes.
    end
    rows[3].cmd[14:0] = 15'(next_random());
    rows[3].resp      = 8'(next_random());
    rows[3].exp_data  = rows[3].resp;
    rows[11].resp     = 8'(next_random());
    rows[11].exp_data = rows[11].resp;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("tx", 32'(1), 32'(tx));
    check_value("cmd_rdy", 32'(1), 32'(cmd_rdy));
    check_value("read_rdy", 32'(0), 32'(read_rdy));

    foreach (rows[i])
    begin
      if (rows[i].is_read)
        run_read(rows[i]);
      else
      begin
        exp_bytes.push_back(rows[i].cmd[15:8]);
        exp_bytes.push_back(rows[i].cmd[7:0]);
        send_command(rows[i].cmd);
      end
    end

    while (dev_bytes.size() < exp_bytes.size())
      @(negedge clk);
    check_value("frame_count", 32'(exp_bytes.size()), 32'(dev_bytes.size()));
    foreach (exp_bytes[i])
      check_value("tx_byte", 32'(exp_bytes[i]), 32'(dev_bytes[i]));

    $display("test done with %0d errors", err_count);
    if (err_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: verilog/uart_cmd_bridge.sv
module uart_cmd_bridge (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                rx,
  output logic                tx,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_rdy,
  output logic                read_err
);

  logic                rx_done;
  uart_cmd_pkg::byte_t rx_data;
  logic                rx_err;

  byte_fifo_if fifo_if ();

  uart_cmd_sequencer uart_cmd_sequencer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .fifo      (fifo_if),
    .rx_done   (rx_done),
    .rx_data   (rx_data),
    .rx_err    (rx_err),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  // transmit bytes, sequencer to serializer.
  byte_fifo byte_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .fifo  (fifo_if)
  );

  uart_tx_serializer uart_tx_serializer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .fifo  (fifo_if),
    .tx    (tx)
  );

  uart_rx_deserializer uart_rx_deserializer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_data (rx_data),
    .rx_err  (rx_err)
  );

endmodule

// File: verilog/uart_rx_deserializer.sv
module uart_rx_deserializer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output logic                rx_done,
  output uart_cmd_pkg::byte_t rx_data,
  output logic                rx_err
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_e;

  rx_state_e                           state;
  logic                                rx_meta;
  logic                                rx_s;
  logic                                rx_q;
  logic [uart_cmd_pkg::FRAME_BITS-2:0] shreg;  // data, parity, stop.
  logic [uart_cmd_pkg::FRAME_BITS-2:0] frame;
  uart_cmd_pkg::clk_cnt_t              clk_cnt;
  uart_cmd_pkg::bit_cnt_t              bit_cnt;
  logic                                last_bit;

  // shift register with the current sample already in.
  assign frame    = {rx_s, shreg[uart_cmd_pkg::FRAME_BITS-2:1]};
  assign last_bit = (bit_cnt == uart_cmd_pkg::FRAME_LAST - 1'b1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_q    <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      rx_q    <= rx_s;  // for edge detect.
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && clk_cnt == uart_cmd_pkg::BIT_LAST)
    begin
      shreg <= frame;
      if (last_bit)
      begin
        rx_data <= frame[uart_cmd_pkg::DATA_BITS-1:0];
        // odd parity over data and parity, plus stop must be high.
        rx_err  <= ~(^frame[uart_cmd_pkg::DATA_BITS:0]) || !frame[uart_cmd_pkg::DATA_BITS+1];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= RX_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      case (state)
        RX_IDLE:
          if (rx_q && !rx_s)
          begin
            clk_cnt <= '0;
            state   <= RX_START;
          end
        RX_START:
        begin
          clk_cnt <= clk_cnt + 1'b1;
          if (clk_cnt == uart_cmd_pkg::BIT_HALF)
          begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_s ? RX_IDLE : RX_BITS;  // high here is a glitch.
          end
        end
        RX_BITS:
        begin
          clk_cnt <= clk_cnt + 1'b1;
          if (clk_cnt == uart_cmd_pkg::BIT_LAST)
          begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit)
            begin
              bit_cnt <= '0;
              rx_done <= 1'b1;
              state   <= RX_IDLE;
            end
          end
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/uart_tx_serializer.sv
module uart_tx_serializer (
  input  logic        clk,
  input  logic        rst_n,
  byte_fifo_if.reader fifo,
  output logic        tx
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FRAME,
    TX_GAP
  } tx_state_e;

  tx_state_e                         state;
  logic [uart_cmd_pkg::FRAME_BITS-1:0] shreg;
  uart_cmd_pkg::clk_cnt_t            clk_cnt;
  uart_cmd_pkg::bit_cnt_t            bit_cnt;
  logic                              bit_end;

  assign fifo.pop = (state == TX_IDLE) && !fifo.empty;
  assign bit_end  = (clk_cnt == uart_cmd_pkg::BIT_LAST);
  assign tx       = shreg[0];  // ones fill behind the stop bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= TX_IDLE;
      shreg   <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      case (state)
        TX_IDLE:
          if (fifo.pop)
          begin
            // stop, odd parity, data, start.
            shreg   <= {1'b1, ~^fifo.pop_data, fifo.pop_data, 1'b0};
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= TX_FRAME;
          end
        TX_FRAME:
        begin
          clk_cnt <= clk_cnt + 1'b1;
          if (bit_end)
          begin
            clk_cnt <= '0;
            shreg   <= {1'b1, shreg[uart_cmd_pkg::FRAME_BITS-1:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == uart_cmd_pkg::FRAME_LAST)
            begin
              bit_cnt <= '0;
              state   <= TX_GAP;
            end
          end
        end
        TX_GAP:
        begin
          clk_cnt <= clk_cnt + 1'b1;
          if (bit_end)
          begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == uart_cmd_pkg::GAP_LAST)
            begin
              bit_cnt <= '0;
              state   <= TX_IDLE;
            end
          end
        end
        default:
          state <= TX_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/byte_fifo.sv
module byte_fifo (
  input logic         clk,
  input logic         rst_n,
  byte_fifo_if.buffer fifo
);

  uart_cmd_pkg::byte_t     mem [uart_cmd_pkg::FIFO_DEPTH];
  uart_cmd_pkg::fifo_ptr_t wr_ptr;
  uart_cmd_pkg::fifo_ptr_t rd_ptr;
  uart_cmd_pkg::fifo_cnt_t count;
  logic                    do_push;
  logic                    do_pop;

  assign fifo.full     = (count == uart_cmd_pkg::FIFO_FULL_CNT);
  assign fifo.empty    = (count == '0);
  assign fifo.pop_data = mem[rd_ptr];

  assign do_push = fifo.push && !fifo.full;
  assign do_pop  = fifo.pop && !fifo.empty;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= fifo.push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == uart_cmd_pkg::FIFO_PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == uart_cmd_pkg::FIFO_PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // both at once leaves the count alone.
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/uart_cmd_sequencer.sv
module uart_cmd_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  byte_fifo_if.writer         fifo,
  input  logic                rx_done,
  input  uart_cmd_pkg::byte_t rx_data,
  input  logic                rx_err,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_rdy,
  output logic                read_err
);

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_PUSH_HI,
    SEQ_PUSH_LO,
    SEQ_AWAIT,
    SEQ_REPORT
  } seq_state_e;

  seq_state_e                 state;
  uart_cmd_pkg::cmd_t         cmd_q;
  uart_cmd_pkg::timeout_cnt_t tmo_cnt;
  logic                       err_q;

  assign cmd_rdy  = (state == SEQ_IDLE);
  assign read_rdy = (state == SEQ_REPORT);
  assign read_err = read_rdy && err_q;

  always_comb
  begin
    fifo.push = (state == SEQ_PUSH_HI) || (state == SEQ_PUSH_LO);
    if (state == SEQ_PUSH_HI)
    begin
      fifo.push_data = cmd_q[uart_cmd_pkg::CMD_BITS-1 -: uart_cmd_pkg::DATA_BITS];
    end
    else
    begin
      fifo.push_data = cmd_q[uart_cmd_pkg::DATA_BITS-1:0];
    end
  end

  // command register, loaded on acceptance.
  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= SEQ_IDLE;
      tmo_cnt   <= '0;
      err_q     <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
          if (cmd_vld)
          begin
            state <= SEQ_PUSH_HI;
          end
        SEQ_PUSH_HI:
          if (!fifo.full)
          begin
            tmo_cnt <= '0;  // timeout runs from the read push.
            state   <= cmd_q[uart_cmd_pkg::DIR_BIT] ? SEQ_PUSH_LO : SEQ_AWAIT;
          end
        SEQ_PUSH_LO:
          if (!fifo.full)
          begin
            state <= SEQ_IDLE;
          end
        SEQ_AWAIT:
        begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (rx_done)
          begin
            read_data <= rx_data;
            err_q     <= rx_err;
            state     <= SEQ_REPORT;
          end
          else if (tmo_cnt == uart_cmd_pkg::TIMEOUT_LAST)
          begin
            read_data <= '0;  // no response.
            err_q     <= 1'b1;
            state     <= SEQ_REPORT;
          end
        end
        SEQ_REPORT:
          state <= SEQ_IDLE;
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/byte_fifo_if.sv
interface byte_fifo_if;

  logic                push;
  uart_cmd_pkg::byte_t push_data;
  logic                full;
  logic                pop;
  uart_cmd_pkg::byte_t pop_data;  // head entry, valid while not empty.
  logic                empty;

  modport writer (
    output push,
    output push_data,
    input  full
  );

  modport reader (
    output pop,
    input  pop_data,
    input  empty
  );

  modport buffer (
    input  push,
    input  push_data,
    input  pop,
    output full,
    output pop_data,
    output empty
  );

endinterface

// File: verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int CLKS_PER_BIT      = 8;    // 434 for 50 MHz at 115200.
  localparam int GAP_BITS          = 2;
  localparam int FIFO_DEPTH        = 4;
  localparam int RESP_TIMEOUT_BITS = 64;

  // frame fields.
  localparam int DATA_BITS  = 8;
  localparam int CMD_BITS   = 16;
  localparam int FRAME_BITS = DATA_BITS + 3;  // start, parity and stop.
  localparam int DIR_BIT    = CMD_BITS - 1;

  localparam int RESP_TIMEOUT_CLKS = RESP_TIMEOUT_BITS * CLKS_PER_BIT;

  localparam int CLK_CNT_W     = $clog2(CLKS_PER_BIT);
  localparam int BIT_CNT_W     = $clog2(FRAME_BITS);
  localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);
  localparam int TIMEOUT_CNT_W = $clog2(RESP_TIMEOUT_CLKS);

  typedef logic [DATA_BITS-1:0]     byte_t;
  typedef logic [CMD_BITS-1:0]      cmd_t;
  typedef logic [CLK_CNT_W-1:0]     clk_cnt_t;
  typedef logic [BIT_CNT_W-1:0]     bit_cnt_t;
  typedef logic [FIFO_PTR_W-1:0]    fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0]    fifo_cnt_t;
  typedef logic [TIMEOUT_CNT_W-1:0] timeout_cnt_t;

  // terminal counts.
  localparam clk_cnt_t     BIT_LAST      = clk_cnt_t'(CLKS_PER_BIT - 1);
  localparam clk_cnt_t     BIT_HALF      = clk_cnt_t'(CLKS_PER_BIT / 2 - 1);
  localparam bit_cnt_t     FRAME_LAST    = bit_cnt_t'(FRAME_BITS - 1);
  localparam bit_cnt_t     GAP_LAST      = bit_cnt_t'(GAP_BITS - 1);
  localparam fifo_ptr_t    FIFO_PTR_LAST = fifo_ptr_t'(FIFO_DEPTH - 1);
  localparam fifo_cnt_t    FIFO_FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);
  localparam timeout_cnt_t TIMEOUT_LAST  = timeout_cnt_t'(RESP_TIMEOUT_CLKS - 1);

endpackage
